/* frontend_pkg.sv */
package frontend_pkg;

    // Bundle and buffer geometry
    localparam int FETCH_W       = 2;
    localparam int IBUF_DEPTH    = 4;
    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PHYS_REGS = 64;

    // Tags above the identity mapping start out free
    localparam int FL_DEPTH   = NUM_PHYS_REGS - NUM_ARCH_REGS;
    localparam int IBUF_PTR_W = $clog2(IBUF_DEPTH);
    localparam int IBUF_CNT_W = $clog2(IBUF_DEPTH + 1);
    localparam int FL_PTR_W   = $clog2(FL_DEPTH);
    localparam int FL_CNT_W   = $clog2(FL_DEPTH + 1);

    typedef logic [31:0]            instr_t;
    typedef logic [31:0]            addr_t;
    typedef logic [31:0]            data_t;
    typedef logic [5:0]             opcode_t;
    typedef logic [5:0]             func_t;
    typedef logic [4:0]             shamt_t;
    typedef logic [4:0]             arch_reg_t;
    typedef logic [5:0]             phys_tag_t;
    typedef logic [FETCH_W-1:0]     slot_mask_t;
    typedef logic [IBUF_PTR_W-1:0]  ibuf_ptr_t;
    typedef logic [IBUF_CNT_W-1:0]  ibuf_cnt_t;
    typedef logic [FL_PTR_W-1:0]    fl_ptr_t;
    typedef logic [FL_CNT_W-1:0]    fl_cnt_t;

    // Major opcodes
    localparam opcode_t OP_RTYPE   = 6'b000000;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_SUBI    = 6'b001001;
    localparam opcode_t OP_ANDI    = 6'b001010;
    localparam opcode_t OP_XORI    = 6'b001011;
    localparam opcode_t OP_ORI     = 6'b001100;
    localparam opcode_t OP_LOAD_W  = 6'b010000;
    localparam opcode_t OP_STORE_W = 6'b010001;
    localparam opcode_t OP_LOAD_B  = 6'b010010;
    localparam opcode_t OP_STORE_B = 6'b010011;
    localparam opcode_t OP_CAS     = 6'b010100;
    localparam opcode_t OP_JMP     = 6'b100000;
    localparam opcode_t OP_CALL    = 6'b100001;
    localparam opcode_t OP_BEQZ    = 6'b100010;
    localparam opcode_t OP_BNEZ    = 6'b100011;
    localparam opcode_t OP_SYS     = 6'b111000;
    localparam opcode_t OP_NOP     = 6'b111111;

    typedef struct packed {
        slot_mask_t                 valid;
        instr_t [FETCH_W-1:0]       instr;
        addr_t  [FETCH_W-1:0]       pc;
    } fetch_bundle_t;

    typedef struct packed {
        logic       valid;
        opcode_t    opcode;
        arch_reg_t  rs1;
        arch_reg_t  rs2;
        arch_reg_t  rd;
        logic       rs1_valid;
        logic       rs2_valid;
        logic       rd_valid;
        data_t      imm;
        addr_t      pc;
        func_t      alu_func;
        shamt_t     shamt;
        logic       is_alu;
        logic       is_load;
        logic       is_store;
        logic       is_branch;
        logic       is_cas;
    } dec_uop_t;

    typedef struct packed {
        logic       valid;
        opcode_t    opcode;
        phys_tag_t  prs1;
        phys_tag_t  prs2;
        phys_tag_t  prd;
        phys_tag_t  old_prd;
        logic       rs1_valid;
        logic       rs2_valid;
        logic       rd_valid;
        data_t      imm;
        addr_t      pc;
        func_t      alu_func;
        shamt_t     shamt;
        logic       is_alu;
        logic       is_load;
        logic       is_store;
        logic       is_branch;
        logic       is_cas;
    } ren_uop_t;

endpackage

/* instr_buffer.sv */
`timescale 1ns/1ps

module instr_buffer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush,

    // Fetch side
    input  logic                        in_valid,
    input  frontend_pkg::fetch_bundle_t in_bundle,
    output logic                        in_ready,

    // Decode side
    input  logic                        pop,
    output logic                        head_valid,
    output frontend_pkg::fetch_bundle_t head_bundle
);

    frontend_pkg::fetch_bundle_t mem [frontend_pkg::IBUF_DEPTH];

    frontend_pkg::ibuf_ptr_t wr_ptr;
    frontend_pkg::ibuf_ptr_t rd_ptr;
    frontend_pkg::ibuf_cnt_t count;

    logic do_push;
    logic do_pop;

    assign in_ready    = (count != frontend_pkg::ibuf_cnt_t'(frontend_pkg::IBUF_DEPTH));
    assign head_valid  = (count != '0);
    assign head_bundle = mem[rd_ptr];

    // Flush wins over both ends
    assign do_push = in_valid && in_ready && !flush;
    assign do_pop  = pop && head_valid && !flush;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= in_bundle;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* decode.sv */
`timescale 1ns/1ps

module decode (
    input  logic                                                head_valid,
    input  frontend_pkg::fetch_bundle_t                         head_bundle,
    input  logic                                                decode_ready,
    input  logic                                                flush,
    output frontend_pkg::dec_uop_t [frontend_pkg::FETCH_W-1:0]  dec_uops
);

    // One slot; everything stays zero unless enabled
    function automatic frontend_pkg::dec_uop_t decode_slot(
        input frontend_pkg::instr_t ins,
        input frontend_pkg::addr_t  pc,
        input logic                 en
    );
        frontend_pkg::dec_uop_t u;

        u = '0;
        if (en) begin
            u.valid  = 1'b1;
            u.opcode = ins[31:26];
            u.pc     = pc;

            case (ins[31:26])
                frontend_pkg::OP_RTYPE: begin
                    u.rd        = ins[25:21];
                    u.rs1       = ins[20:16];
                    u.rs2       = ins[15:11];
                    u.shamt     = ins[10:6];
                    u.alu_func  = ins[5:0];
                    u.rd_valid  = 1'b1;
                    u.rs1_valid = 1'b1;
                    u.rs2_valid = 1'b1;
                    u.is_alu    = 1'b1;
                end

                frontend_pkg::OP_ADDI,
                frontend_pkg::OP_SUBI,
                frontend_pkg::OP_ANDI,
                frontend_pkg::OP_XORI,
                frontend_pkg::OP_ORI: begin
                    u.rd        = ins[25:21];
                    u.rs1       = ins[20:16];
                    u.imm       = {{16{ins[15]}}, ins[15:0]};
                    u.rd_valid  = 1'b1;
                    u.rs1_valid = 1'b1;
                    u.is_alu    = 1'b1;
                end

                frontend_pkg::OP_LOAD_W,
                frontend_pkg::OP_LOAD_B: begin
                    u.rd        = ins[25:21];
                    u.rs1       = ins[20:16];
                    u.imm       = {{16{ins[15]}}, ins[15:0]};
                    u.rd_valid  = 1'b1;
                    u.rs1_valid = 1'b1;
                    u.is_load   = 1'b1;
                end

                // Store data register sits where rd would be
                frontend_pkg::OP_STORE_W,
                frontend_pkg::OP_STORE_B: begin
                    u.rs1       = ins[20:16];
                    u.rs2       = ins[25:21];
                    u.imm       = {{16{ins[15]}}, ins[15:0]};
                    u.rs1_valid = 1'b1;
                    u.rs2_valid = 1'b1;
                    u.is_store  = 1'b1;
                end

                frontend_pkg::OP_CAS: begin
                    u.rd        = ins[25:21];
                    u.rs1       = ins[20:16];
                    u.rs2       = ins[15:11];
                    u.rd_valid  = 1'b1;
                    u.rs1_valid = 1'b1;
                    u.rs2_valid = 1'b1;
                    u.is_cas    = 1'b1;
                end

                // Word offset, byte address
                frontend_pkg::OP_JMP,
                frontend_pkg::OP_CALL: begin
                    u.imm       = {{4{ins[25]}}, ins[25:0], 2'b00};
                    u.is_branch = 1'b1;
                end

                frontend_pkg::OP_BEQZ,
                frontend_pkg::OP_BNEZ: begin
                    u.rs1       = ins[25:21];
                    u.imm       = {{9{ins[20]}}, ins[20:0], 2'b00};
                    u.rs1_valid = 1'b1;
                    u.is_branch = 1'b1;
                end

                frontend_pkg::OP_SYS: begin
                    u.imm = {{6{ins[25]}}, ins[25:0]};
                end

                frontend_pkg::OP_NOP: begin
                    // No operands, no class
                    u.imm = '0;
                end

                default: begin
                    // Undefined opcode passes through as a valid empty op
                    u.imm = '0;
                end
            endcase
        end
        return u;
    endfunction

    always_comb begin
        for (int i = 0; i < frontend_pkg::FETCH_W; i++) begin
            dec_uops[i] = decode_slot(head_bundle.instr[i],
                                      head_bundle.pc[i],
                                      head_bundle.valid[i] && head_valid &&
                                      decode_ready && !flush);
        end
    end

endmodule

/* rename.sv */
`timescale 1ns/1ps

module rename (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                flush,
    input  frontend_pkg::dec_uop_t [frontend_pkg::FETCH_W-1:0]  dec_uops,
    output logic                                                decode_ready,
    output logic                                                ren_valid,
    output frontend_pkg::ren_uop_t [frontend_pkg::FETCH_W-1:0]  ren_uops
);

    // Register alias table
    frontend_pkg::phys_tag_t map_table [frontend_pkg::NUM_ARCH_REGS];

    // Free list, read from the head only
    frontend_pkg::phys_tag_t free_tags [frontend_pkg::FL_DEPTH];
    frontend_pkg::fl_ptr_t   fl_head;
    frontend_pkg::fl_cnt_t   free_count;

    logic [frontend_pkg::FETCH_W-1:0]                       alloc;
    frontend_pkg::phys_tag_t [frontend_pkg::FETCH_W-1:0]    new_tag;
    frontend_pkg::fl_cnt_t                                  n_alloc;
    frontend_pkg::ren_uop_t [frontend_pkg::FETCH_W-1:0]     ren_next;

    // Only the free count, so nothing loops back through decode
    assign decode_ready = (free_count >= frontend_pkg::fl_cnt_t'(frontend_pkg::FETCH_W));

    // Tags handed out in slot order
    always_comb begin
        n_alloc = '0;
        for (int i = 0; i < frontend_pkg::FETCH_W; i++) begin
            alloc[i]   = dec_uops[i].valid && dec_uops[i].rd_valid && (dec_uops[i].rd != '0);
            new_tag[i] = free_tags[fl_head + frontend_pkg::fl_ptr_t'(n_alloc)];
            if (alloc[i]) begin
                n_alloc = n_alloc + 1'b1;
            end
        end
    end

    always_comb begin
        frontend_pkg::dec_uop_t u;

        for (int i = 0; i < frontend_pkg::FETCH_W; i++) begin
            u = dec_uops[i];

            ren_next[i]           = '0;
            ren_next[i].valid     = u.valid;
            ren_next[i].opcode    = u.opcode;
            ren_next[i].rs1_valid = u.rs1_valid;
            ren_next[i].rs2_valid = u.rs2_valid;
            ren_next[i].rd_valid  = u.rd_valid;
            ren_next[i].imm       = u.imm;
            ren_next[i].pc        = u.pc;
            ren_next[i].alu_func  = u.alu_func;
            ren_next[i].shamt     = u.shamt;
            ren_next[i].is_alu    = u.is_alu;
            ren_next[i].is_load   = u.is_load;
            ren_next[i].is_store  = u.is_store;
            ren_next[i].is_branch = u.is_branch;
            ren_next[i].is_cas    = u.is_cas;

            if (u.valid && u.rs1_valid) begin
                ren_next[i].prs1 = map_table[u.rs1];
            end
            if (u.valid && u.rs2_valid) begin
                ren_next[i].prs2 = map_table[u.rs2];
            end
            if (alloc[i]) begin
                ren_next[i].prd     = new_tag[i];
                ren_next[i].old_prd = map_table[u.rd];
            end

            // Older slots in the same bundle override the table, latest wins
            for (int j = 0; j < i; j++) begin
                if (alloc[j] && u.valid && u.rs1_valid && dec_uops[j].rd == u.rs1) begin
                    ren_next[i].prs1 = new_tag[j];
                end
                if (alloc[j] && u.valid && u.rs2_valid && dec_uops[j].rd == u.rs2) begin
                    ren_next[i].prs2 = new_tag[j];
                end
                if (alloc[j] && alloc[i] && dec_uops[j].rd == u.rd) begin
                    ren_next[i].old_prd = new_tag[j];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int r = 0; r < frontend_pkg::NUM_ARCH_REGS; r++) begin
                map_table[r] <= frontend_pkg::phys_tag_t'(r);
            end
            for (int k = 0; k < frontend_pkg::FL_DEPTH; k++) begin
                free_tags[k] <= frontend_pkg::phys_tag_t'(frontend_pkg::NUM_ARCH_REGS + k);
            end
            fl_head    <= '0;
            free_count <= frontend_pkg::fl_cnt_t'(frontend_pkg::FL_DEPTH);
            ren_uops   <= '0;
        end else begin
            for (int i = 0; i < frontend_pkg::FETCH_W; i++) begin
                if (alloc[i]) begin
                    map_table[dec_uops[i].rd] <= new_tag[i];
                end
            end
            fl_head    <= fl_head + frontend_pkg::fl_ptr_t'(n_alloc);
            free_count <= free_count - n_alloc;
            ren_uops   <= ren_next;
        end
    end

    always_comb begin
        ren_valid = 1'b0;
        for (int i = 0; i < frontend_pkg::FETCH_W; i++) begin
            ren_valid = ren_valid | ren_uops[i].valid;
        end
    end

endmodule

/* frontend_top.sv */
`timescale 1ns/1ps

module frontend_top (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                flush,

    // Fetch
    input  logic                                                fetch_valid,
    input  frontend_pkg::fetch_bundle_t                         fetch_bundle,
    output logic                                                fetch_ready,

    // Renamed micro-ops to dispatch
    output logic                                                ren_valid,
    output frontend_pkg::ren_uop_t [frontend_pkg::FETCH_W-1:0]  ren_uops
);

    logic                                               head_valid;
    frontend_pkg::fetch_bundle_t                        head_bundle;
    logic                                               decode_ready;
    frontend_pkg::dec_uop_t [frontend_pkg::FETCH_W-1:0] dec_uops;

    instr_buffer u_instr_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .in_valid    (fetch_valid),
        .in_bundle   (fetch_bundle),
        .in_ready    (fetch_ready),
        .pop         (decode_ready),
        .head_valid  (head_valid),
        .head_bundle (head_bundle)
    );

    decode u_decode (
        .head_valid   (head_valid),
        .head_bundle  (head_bundle),
        .decode_ready (decode_ready),
        .flush        (flush),
        .dec_uops     (dec_uops)
    );

    rename u_rename (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .dec_uops     (dec_uops),
        .decode_ready (decode_ready),
        .ren_valid    (ren_valid),
        .ren_uops     (ren_uops)
    );

endmodule

/* frontend_tb.sv */
`timescale 1ns/1ps

module frontend_tb;

    logic                                               clk;
    logic                                               rst_n;
    logic                                               flush;
    logic                                               fetch_valid;
    frontend_pkg::fetch_bundle_t                        fetch_bundle;
    logic                                               fetch_ready;
    logic                                               ren_valid;
    frontend_pkg::ren_uop_t [frontend_pkg::FETCH_W-1:0] ren_uops;

    // Commands in file order, expected words seven per slot
    byte                         cmd_kind   [$];
    logic [31:0]                 cmd_arg    [$];
    frontend_pkg::fetch_bundle_t cmd_bundle [$];
    logic [31:0]                 exp_words  [$];

    // Accepted bundles still waiting for their renamed output
    frontend_pkg::fetch_bundle_t sent_bundles [$];

    int checks;
    int mismatches;
    int other_errors;
    int golden_lines;
    int cycles;
    int cycle_limit;

    frontend_top u_frontend_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .fetch_valid  (fetch_valid),
        .fetch_bundle (fetch_bundle),
        .fetch_ready  (fetch_ready),
        .ren_valid    (ren_valid),
        .ren_uops     (ren_uops)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic string field_name(input int k);
        case (k)
            0:       return "valid";
            1:       return "flags";
            2:       return "imm";
            3:       return "prs1";
            4:       return "prs2";
            5:       return "prd";
            default: return "old_prd";
        endcase
    endfunction

    // Flags pack the usage bits above the five class bits
    function automatic logic [31:0] slot_field(input frontend_pkg::ren_uop_t u, input int k);
        case (k)
            0:       return {31'd0, u.valid};
            1:       return {24'd0, u.rs1_valid, u.rs2_valid, u.rd_valid, u.is_alu,
                             u.is_load, u.is_store, u.is_branch, u.is_cas};
            2:       return u.imm;
            3:       return {26'd0, u.prs1};
            4:       return {26'd0, u.prs2};
            5:       return {26'd0, u.prd};
            default: return {26'd0, u.old_prd};
        endcase
    endfunction

    task automatic compare_output();
        logic [31:0]                 exp;
        frontend_pkg::fetch_bundle_t b;
        frontend_pkg::instr_t        ins;
        logic                        en;
        logic                        rtype;

        b = sent_bundles.pop_front();
        for (int s = 0; s < frontend_pkg::FETCH_W; s++) begin
            for (int k = 0; k < 7; k++) begin
                exp = exp_words.pop_front();
                check_value($sformatf("slot %0d %s", s, field_name(k)),
                            slot_field(ren_uops[s], k), exp);
            end

            // Pass-through fields follow the fetched word and PC
            en    = b.valid[s];
            ins   = b.instr[s];
            rtype = en && (ins[31:26] == frontend_pkg::OP_RTYPE);
            check_value($sformatf("slot %0d opcode", s), {26'd0, ren_uops[s].opcode},
                        en ? {26'd0, ins[31:26]} : 32'd0);
            check_value($sformatf("slot %0d pc", s), ren_uops[s].pc,
                        en ? b.pc[s] : 32'd0);
            check_value($sformatf("slot %0d alu_func", s), {26'd0, ren_uops[s].alu_func},
                        rtype ? {26'd0, ins[5:0]} : 32'd0);
            check_value($sformatf("slot %0d shamt", s), {27'd0, ren_uops[s].shamt},
                        rtype ? {27'd0, ins[10:6]} : 32'd0);
        end
    endtask

    task automatic read_golden();
        int                          fd;
        int                          n;
        byte                         kind;
        string                       line;
        string                       rest;
        logic [31:0]                 w [14];
        frontend_pkg::fetch_bundle_t b;

        fd = $fopen("frontend_golden.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open frontend_golden.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            kind = line.getc(0);
            rest = line.substr(1, line.len() - 1);
            case (kind)
                "B", "I", "F", "R": begin
                    n = $sscanf(rest, "%h %h %h %h %h", w[0], w[1], w[2], w[3], w[4]);
                    if (kind == "B" && n != 5) begin
                        other_errors++;
                        $display("bundle line with missing fields: %s", line);
                    end
                    b.valid    = frontend_pkg::slot_mask_t'(w[0]);
                    b.instr[0] = w[1];
                    b.instr[1] = w[2];
                    b.pc[0]    = w[3];
                    b.pc[1]    = w[4];
                    cmd_kind.push_back(kind);
                    cmd_arg.push_back(w[0]);
                    cmd_bundle.push_back(b);
                    golden_lines++;
                end
                "E": begin
                    n = $sscanf(rest, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                w[0], w[1], w[2], w[3], w[4], w[5], w[6],
                                w[7], w[8], w[9], w[10], w[11], w[12], w[13]);
                    if (n != 14) begin
                        other_errors++;
                        $display("expected line with missing fields: %s", line);
                    end
                    for (int k = 0; k < 14; k++) begin
                        exp_words.push_back(w[k]);
                    end
                    golden_lines++;
                end
                "#", " ", "\n", "\r": begin
                end
                default: begin
                    other_errors++;
                    $display("unknown line in golden file: %s", line);
                end
            endcase
        end
        $fclose(fd);
    endtask

    task automatic print_summary();
        $display("summary: %0d checks, %0d mismatches, %0d other failures",
                 checks, mismatches, other_errors);
    endtask

    // Every output cycle consumes one expected entry
    always @(negedge clk) begin
        if (rst_n && ren_valid) begin
            if (exp_words.size() < 7 * frontend_pkg::FETCH_W || sent_bundles.size() == 0) begin
                other_errors++;
                $display("renamed output at %0d ns with no expected entry left", $time);
            end else begin
                compare_output();
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            print_summary();
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        logic ready;

        rst_n        = 1'b0;
        flush        = 1'b0;
        fetch_valid  = 1'b0;
        fetch_bundle = '0;
        read_golden();
        cycle_limit = 20 * golden_lines + 100;

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < cmd_kind.size(); i++) begin
            case (cmd_kind[i])
                "B": begin
                    fetch_valid  = 1'b1;
                    fetch_bundle = cmd_bundle[i];
                    // Hold the bundle until the buffer takes it
                    do begin
                        @(negedge clk);
                        ready = fetch_ready;
                        @(posedge clk);
                        #1;
                    end while (!ready);
                    fetch_valid = 1'b0;
                    if (|cmd_bundle[i].valid) begin
                        sent_bundles.push_back(cmd_bundle[i]);
                    end
                end
                "I": begin
                    repeat (cmd_arg[i]) @(posedge clk);
                    #1;
                end
                "F": begin
                    flush = 1'b1;
                    @(posedge clk);
                    #1;
                    flush = 1'b0;
                    // Everything still queued is dropped
                    sent_bundles.delete();
                end
                default: begin
                    @(negedge clk);
                    check_value("fetch_ready", {31'd0, fetch_ready}, cmd_arg[i]);
                    @(posedge clk);
                    #1;
                end
            endcase
        end

        if (exp_words.size() != 0) begin
            other_errors++;
            $display("%0d expected outputs never appeared",
                     exp_words.size() / (7 * frontend_pkg::FETCH_W));
        end
        print_summary();
        if (mismatches == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* frontend_golden.txt */
# B mask instr0 instr1 pc0 pc1 / I idle cycles / F flush / R expected fetch_ready (all hex)
# E per slot: valid flags imm prs1 prs2 prd old_prd with flags = rs1v rs2v rdv alu ld st br cas
R 1
B 3 2020fffc 00411820 00001000 00001004
E 1 b0 fffffffc 00 00 20 01 1 f0 00000000 20 03 21 02
B 3 40620008 4c61fff0 00001008 0000100c
E 1 a8 00000008 21 00 22 03 1 c4 fffffff0 20 22 00 00
B 3 50830800 889ffffe 00001010 00001014
E 1 e1 00000000 22 20 23 04 1 82 fffffff8 23 00 00 00
B 3 80000040 e2000005 00001018 0000101c
E 1 02 00000100 00 00 00 00 1 00 fe000005 00 00 00 00
B 1 87fffff0 20a00001 00001020 00001024
E 1 02 ffffffc0 00 00 00 00 0 00 00000000 00 00 00 00
B 3 f8a21234 20010005 00001028 0000102c
E 1 00 00000000 00 00 00 00 1 b0 00000005 20 00 00 00
B 3 24a50001 20c50002 00001030 00001034
B 3 28e70001 21070002 00001038 0000103c
B 3 2d290001 21490002 00001040 00001044
B 3 316b0001 218b0002 00001048 0000104c
B 3 25ad0001 21cd0002 00001050 00001054
B 3 29ef0001 220f0002 00001058 0000105c
B 3 2e310001 22510002 00001060 00001064
B 3 32730001 22930002 00001068 0000106c
B 3 26b50001 22d50002 00001070 00001074
B 3 2af70001 23170002 00001078 0000107c
B 3 2f390001 23590002 00001080 00001084
B 3 337b0001 239b0002 00001088 0000108c
B 3 27bd0001 23dd0002 00001090 00001094
B 3 fc000000 23ffffff 00001098 0000109c
E 1 b0 00000001 05 00 24 05 1 b0 00000002 24 00 25 06
E 1 b0 00000001 07 00 26 07 1 b0 00000002 26 00 27 08
E 1 b0 00000001 09 00 28 09 1 b0 00000002 28 00 29 0a
E 1 b0 00000001 0b 00 2a 0b 1 b0 00000002 2a 00 2b 0c
E 1 b0 00000001 0d 00 2c 0d 1 b0 00000002 2c 00 2d 0e
E 1 b0 00000001 0f 00 2e 0f 1 b0 00000002 2e 00 2f 10
E 1 b0 00000001 11 00 30 11 1 b0 00000002 30 00 31 12
E 1 b0 00000001 13 00 32 13 1 b0 00000002 32 00 33 14
E 1 b0 00000001 15 00 34 15 1 b0 00000002 34 00 35 16
E 1 b0 00000001 17 00 36 17 1 b0 00000002 36 00 37 18
E 1 b0 00000001 19 00 38 19 1 b0 00000002 38 00 39 1a
E 1 b0 00000001 1b 00 3a 1b 1 b0 00000002 3a 00 3b 1c
E 1 b0 00000001 1d 00 3c 1d 1 b0 00000002 3c 00 3d 1e
E 1 00 00000000 00 00 00 00 1 b0 ffffffff 1f 00 3e 1f
B 3 20210001 20420001 000010a0 000010a4
B 3 20630001 20840001 000010a8 000010ac
B 3 20a50001 20c60001 000010b0 000010b4
B 3 20e70001 21080001 000010b8 000010bc
R 0
F
B 3 00a11022 40c50004 00002000 00002004
E 1 f0 00000000 01 02 20 05 1 a8 00000004 20 00 21 06
I 8

/* compile.f */
frontend_pkg.sv
instr_buffer.sv
decode.sv
rename.sv
frontend_top.sv
frontend_tb.sv

/* Bender.yml */
package:
  name: frontend

sources:
  - files:
      - frontend_pkg.sv
      - instr_buffer.sv
      - decode.sv
      - rename.sv
      - frontend_top.sv
  - target: test
    files:
      - frontend_tb.sv
